//--- Bender.yml
package:
  name: cp0

sources:
  - hdl/cp0_pkg.sv
  - hdl/cp0_regfile.sv
  - hdl/cp0_exc_ctrl.sv
  - hdl/cp0_top.sv
  - target: simulation
    files:
      - sim/cp0_tb.sv

//--- hdl/cp0_exc_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module cp0_exc_ctrl (
    input  wire                     exc_valid_i,
    input  wire cp0_pkg::exc_code_e exc_code_i,
    input  wire [31:0]              exc_pc_i,
    input  wire                     exc_bd_i,
    input  wire [31:0]              exc_bad_vaddr_i,
    input  wire [7:0]               exc_asid_i,
    input  wire                     eret_i,
    input  wire [5:0]               hw_int_i,
    input  wire                     timer_int_i,
    input  wire [1:0]               software_int_i,
    input  wire [7:0]               interrupt_mask_i,
    input  wire                     allow_int_i,
    input  wire                     in_exl_i,
    input  wire                     special_int_vec_i,
    input  wire                     boot_exp_vec_i,
    input  wire [19:0]              ebase_i,
    input  wire [31:0]              epc_i,
    output logic                    take_exc_o,
    output logic [31:0]             target_pc_o,
    output logic                    en_exp_o,
    output cp0_pkg::exc_code_e      exp_code_o,
    output logic [31:0]             exp_epc_o,
    output logic                    exp_bd_o,
    output logic [31:0]             exp_bad_vaddr_o,
    output logic                    exp_badv_we_o,
    output logic [7:0]              exp_asid_o,
    output logic                    exp_asid_we_o,
    output logic                    clean_exl_o
);

    logic [7:0]  pending;
    logic [7:0]  masked;
    logic        int_take;
    logic        addr_exc;
    logic [31:0] vec_base;
    logic [11:0] vec_offset;

    assign pending  = {hw_int_i[5] | timer_int_i, hw_int_i[4:0], software_int_i}; // IP7..IP0
    assign masked   = pending & interrupt_mask_i;
    assign int_take = allow_int_i && !in_exl_i && (|masked) && !eret_i;

    // Faults that report an address
    always_comb begin
        case (exc_code_i)
            cp0_pkg::ADEL, cp0_pkg::ADES, cp0_pkg::TLBL, cp0_pkg::TLBS, cp0_pkg::MOD:
                addr_exc = 1'b1;
            default:
                addr_exc = 1'b0;
        endcase
    end

    assign en_exp_o        = int_take || exc_valid_i;
    assign exp_code_o      = int_take ? cp0_pkg::INT : exc_code_i; // Interrupt wins
    assign exp_epc_o       = exc_bd_i ? exc_pc_i - 32'd4 : exc_pc_i; // Point at the branch
    assign exp_bd_o        = exc_bd_i;
    assign exp_bad_vaddr_o = exc_bad_vaddr_i;
    assign exp_badv_we_o   = exc_valid_i && !int_take && addr_exc;
    assign exp_asid_o      = exc_asid_i;
    assign exp_asid_we_o   = exp_badv_we_o;
    assign clean_exl_o     = eret_i;

    assign vec_base   = boot_exp_vec_i ? cp0_pkg::BOOT_VECTOR_BASE : {ebase_i, 12'h000};
    assign vec_offset = (int_take && special_int_vec_i) ? cp0_pkg::SPECIAL_INT_OFFSET
                                                        : cp0_pkg::GENERAL_OFFSET;

    assign take_exc_o  = en_exp_o || eret_i;
    assign target_pc_o = eret_i ? epc_i : vec_base + {20'h0, vec_offset};

    // The pipeline never retires ERET on a faulting instruction
    always_comb begin
        assert final ({exc_valid_i, eret_i} !== 2'b11)
            else $error("exc_valid_i and eret_i high in the same cycle");
    end

endmodule

`default_nettype wire

//--- hdl/cp0_pkg.sv
`default_nettype none

package cp0_pkg;

    // Register selector, {number, select}
    typedef enum logic [7:0] {
        INDEX    = {5'd0, 3'd0},
        ENTRYLO0 = {5'd2, 3'd0},
        ENTRYLO1 = {5'd3, 3'd0},
        CONTEXT  = {5'd4, 3'd0},
        BADVADDR = {5'd8, 3'd0},
        COUNT    = {5'd9, 3'd0},
        ENTRYHI  = {5'd10, 3'd0},
        COMPARE  = {5'd11, 3'd0},
        STATUS   = {5'd12, 3'd0},
        CAUSE    = {5'd13, 3'd0},
        EPC      = {5'd14, 3'd0},
        PRID     = {5'd15, 3'd0},
        EBASE    = {5'd15, 3'd1},
        CONFIG   = {5'd16, 3'd0},
        CONFIG1  = {5'd16, 3'd1}
    } cp0_reg_e;

    typedef enum logic [4:0] {
        INT  = 5'd0,
        MOD  = 5'd1,
        TLBL = 5'd2,
        TLBS = 5'd3,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12
    } exc_code_e;

    localparam logic [31:0] STATUS_RESET  = 32'h1040_0004; // CU0, BEV, ERL
    localparam logic [31:0] EBASE_RESET   = 32'h8000_0000;
    localparam logic [31:0] PRID_VALUE    = 32'h0001_8000; // 4Kc style
    localparam logic [31:0] CONFIG1_VALUE = 32'h1E00_0000; // 16 TLB entries, no caches

    // Config fixed part, M set and AR release 1
    localparam logic [31:0] CONFIG_FIXED    = 32'h8000_0080;
    localparam logic [2:0]  CONFIG_K0_RESET = 3'd2; // Uncached

    localparam logic [31:0] STATUS_WMASK = 32'h1040_FF17;
    localparam logic [31:0] CAUSE_WMASK  = 32'h0080_0300; // IV, IP1..IP0

    localparam logic [31:0] BOOT_VECTOR_BASE   = 32'hBFC0_0200;
    localparam logic [11:0] GENERAL_OFFSET     = 12'h180;
    localparam logic [11:0] SPECIAL_INT_OFFSET = 12'h200;

    localparam logic [1:0] COUNT_DIV = 2'd3; // Count ticks every 4 clocks

endpackage

`default_nettype wire

//--- hdl/cp0_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module cp0_regfile (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [4:0]               rd_addr_i,
    input  wire [2:0]               rd_sel_i,
    input  wire [4:0]               dbg_rd_addr_i,
    input  wire [2:0]               dbg_rd_sel_i,
    input  wire                     we_i,
    input  wire [4:0]               wr_addr_i,
    input  wire [2:0]               wr_sel_i,
    input  wire [31:0]              wdata_i,
    input  wire [5:0]               hw_int_i,
    input  wire                     clean_exl_i,
    input  wire                     en_exp_i,
    input  wire [31:0]              exp_epc_i,
    input  wire                     exp_bd_i,
    input  wire cp0_pkg::exc_code_e exp_code_i,
    input  wire [31:0]              exp_bad_vaddr_i,
    input  wire                     exp_badv_we_i,
    input  wire [7:0]               exp_asid_i,
    input  wire                     exp_asid_we_i,
    input  wire                     we_probe_i,
    input  wire [31:0]              probe_result_i,
    output logic [31:0]             rdata_o,
    output logic [31:0]             dbg_rdata_o,
    output logic                    timer_int_o,
    output logic                    user_mode_o,
    output logic [19:0]             ebase_o,
    output logic [31:0]             epc_o,
    output logic [83:0]             tlb_config_o,
    output logic                    allow_int_o,
    output logic [1:0]              software_int_o,
    output logic [7:0]              interrupt_mask_o,
    output logic                    special_int_vec_o,
    output logic                    boot_exp_vec_o,
    output logic [7:0]              asid_o,
    output logic                    in_exl_o
);

    logic [31:0] status_q;
    logic [31:0] cause_q;
    logic [31:0] count_q;
    logic [31:0] compare_q;
    logic [1:0]  prescale_q;
    logic [17:0] ebase_q;      // EBase[29:12]
    logic [2:0]  config_k0_q;

    logic [31:0] epc_q;
    logic [31:0] badvaddr_q;
    logic [8:0]  ptebase_q;
    logic [18:0] badvpn2_q;
    logic [18:0] vpn2_q;
    logic [7:0]  asid_q;
    logic [26:0] entrylo_q [2]; // {PFN, D, V, G}
    logic        probe_q;
    logic [3:0]  idx_q;

    logic [7:0]        rd_raw [2];
    cp0_pkg::cp0_reg_e wr_key;

    assign wr_key = cp0_pkg::cp0_reg_e'({wr_addr_i, wr_sel_i});
    assign rd_raw[0] = {rd_addr_i, rd_sel_i};
    assign rd_raw[1] = {dbg_rd_addr_i, dbg_rd_sel_i};

    assign user_mode_o       = status_q[4:1] == 4'b1000; // UM set, ERL and EXL clear
    assign allow_int_o       = status_q[2:0] == 3'b001;
    assign in_exl_o          = status_q[1];
    assign interrupt_mask_o  = status_q[15:8];
    assign boot_exp_vec_o    = status_q[22];
    assign special_int_vec_o = cause_q[23];
    assign software_int_o    = cause_q[9:8];
    assign ebase_o           = {2'b10, ebase_q};
    assign epc_o             = epc_q;
    assign asid_o            = asid_q;

    // Staging fields handed to the TLB on a write
    assign tlb_config_o = {asid_q, entrylo_q[1][0] & entrylo_q[0][0], vpn2_q,
                           entrylo_q[1][26:1], entrylo_q[0][26:1], idx_q};

    for (genvar p = 0; p < 2; p++) begin : g_rd
        cp0_pkg::cp0_reg_e key;
        logic [31:0]       data;

        assign key = cp0_pkg::cp0_reg_e'(rd_raw[p]);

        always_comb begin
            case (key)
                cp0_pkg::INDEX:    data = {probe_q, 27'b0, idx_q};
                cp0_pkg::ENTRYLO0: data = {2'b0, entrylo_q[0][26:3], 3'b0, entrylo_q[0][2:0]};
                cp0_pkg::ENTRYLO1: data = {2'b0, entrylo_q[1][26:3], 3'b0, entrylo_q[1][2:0]};
                cp0_pkg::CONTEXT:  data = {ptebase_q, badvpn2_q, 4'b0};
                cp0_pkg::BADVADDR: data = badvaddr_q;
                cp0_pkg::COUNT:    data = count_q;
                cp0_pkg::ENTRYHI:  data = {vpn2_q, 5'b0, asid_q};
                cp0_pkg::COMPARE:  data = compare_q;
                cp0_pkg::STATUS:   data = status_q;
                cp0_pkg::CAUSE:    data = {cause_q[31], 7'b0, cause_q[23], 7'b0, hw_int_i,
                                           cause_q[9:8], 1'b0, cause_q[6:2], 2'b0};
                cp0_pkg::EPC:      data = epc_q;
                cp0_pkg::PRID:     data = cp0_pkg::PRID_VALUE;
                cp0_pkg::EBASE:    data = {2'b10, ebase_q, 12'b0};
                cp0_pkg::CONFIG:   data = cp0_pkg::CONFIG_FIXED | {29'b0, config_k0_q};
                cp0_pkg::CONFIG1:  data = cp0_pkg::CONFIG1_VALUE;
                default:           data = 32'b0;
            endcase
        end
    end

    assign rdata_o     = g_rd[0].data;
    assign dbg_rdata_o = g_rd[1].data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q    <= cp0_pkg::STATUS_RESET;
            cause_q     <= 32'b0;
            count_q     <= 32'b0;
            compare_q   <= 32'b0;
            prescale_q  <= 2'b0;
            timer_int_o <= 1'b0;
            ebase_q     <= cp0_pkg::EBASE_RESET[29:12];
            config_k0_q <= cp0_pkg::CONFIG_K0_RESET;
        end else begin
            prescale_q <= prescale_q + 2'd1;
            if (prescale_q == cp0_pkg::COUNT_DIV) begin
                count_q <= count_q + 32'd1;
            end
            if (compare_q != 32'b0 && compare_q == count_q) begin
                timer_int_o <= 1'b1;
            end
            if (we_i) begin
                case (wr_key)
                    cp0_pkg::STATUS: status_q <= (status_q & ~cp0_pkg::STATUS_WMASK) |
                                                 (wdata_i & cp0_pkg::STATUS_WMASK);
                    cp0_pkg::CAUSE:  cause_q <= (cause_q & ~cp0_pkg::CAUSE_WMASK) |
                                                (wdata_i & cp0_pkg::CAUSE_WMASK);
                    cp0_pkg::COUNT:  count_q <= wdata_i;
                    cp0_pkg::COMPARE: begin
                        compare_q   <= wdata_i;
                        timer_int_o <= 1'b0; // Acknowledge
                    end
                    cp0_pkg::EBASE:  ebase_q <= wdata_i[29:12];
                    cp0_pkg::CONFIG: config_k0_q <= wdata_i[2:0];
                    default: ;
                endcase
            end
            // Capture last so it overrides a software write
            if (en_exp_i) begin
                status_q[1]   <= 1'b1;
                cause_q[31]   <= exp_bd_i;
                cause_q[6:2]  <= exp_code_i;
            end
            if (clean_exl_i) begin
                status_q[1] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            case (wr_key)
                cp0_pkg::EPC:      epc_q <= wdata_i;
                cp0_pkg::CONTEXT:  ptebase_q <= wdata_i[31:23];
                cp0_pkg::ENTRYHI: begin
                    vpn2_q <= wdata_i[31:13];
                    asid_q <= wdata_i[7:0];
                end
                cp0_pkg::ENTRYLO0: entrylo_q[0] <= {wdata_i[29:6], wdata_i[2:0]};
                cp0_pkg::ENTRYLO1: entrylo_q[1] <= {wdata_i[29:6], wdata_i[2:0]};
                cp0_pkg::INDEX:    idx_q <= wdata_i[3:0];
                default: ;
            endcase
        end
        if (we_probe_i) begin
            probe_q <= probe_result_i[31]; // P bit, set on a miss
            idx_q   <= probe_result_i[3:0];
        end
        if (en_exp_i) begin
            epc_q <= exp_epc_i;
            if (exp_badv_we_i) begin
                badvaddr_q <= exp_bad_vaddr_i;
                badvpn2_q  <= exp_bad_vaddr_i[31:13];
                vpn2_q     <= exp_bad_vaddr_i[31:13];
            end
            if (exp_asid_we_i) begin
                asid_q <= exp_asid_i;
            end
        end
    end

    // Exception entry and ERET come from the controller as exclusive strobes
    assert property (@(posedge clk) disable iff (!rst_n) !(en_exp_i && clean_exl_i))
        else $error("exception capture and EXL clear in the same cycle");

endmodule

`default_nettype wire

//--- hdl/cp0_top.sv
`timescale 1ns/10ps
`default_nettype none

module cp0_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [4:0]               rd_addr_i,
    input  wire [2:0]               rd_sel_i,
    input  wire [4:0]               dbg_rd_addr_i,
    input  wire [2:0]               dbg_rd_sel_i,
    input  wire                     we_i,
    input  wire [4:0]               wr_addr_i,
    input  wire [2:0]               wr_sel_i,
    input  wire [31:0]              wdata_i,
    input  wire [5:0]               hw_int_i,
    input  wire                     we_probe_i,
    input  wire [31:0]              probe_result_i,
    input  wire                     exc_valid_i,
    input  wire cp0_pkg::exc_code_e exc_code_i,
    input  wire [31:0]              exc_pc_i,
    input  wire                     exc_bd_i,
    input  wire [31:0]              exc_bad_vaddr_i,
    input  wire [7:0]               exc_asid_i,
    input  wire                     eret_i,
    output logic [31:0]             rdata_o,
    output logic [31:0]             dbg_rdata_o,
    output logic                    take_exc_o,
    output logic [31:0]             target_pc_o,
    output logic                    timer_int_o,
    output logic                    user_mode_o,
    output logic [7:0]              asid_o,
    output logic [83:0]             tlb_config_o
);

    wire                     allow_int;
    wire                     in_exl;
    wire [7:0]               interrupt_mask;
    wire [1:0]               software_int;
    wire                     special_int_vec;
    wire                     boot_exp_vec;
    wire [19:0]              ebase;
    wire [31:0]              epc;
    wire                     en_exp;
    cp0_pkg::exc_code_e      exp_code;
    wire [31:0]              exp_epc;
    wire                     exp_bd;
    wire [31:0]              exp_bad_vaddr;
    wire                     exp_badv_we;
    wire [7:0]               exp_asid;
    wire                     exp_asid_we;
    wire                     clean_exl;

    cp0_regfile i_cp0_regfile (
        .clk               (clk),
        .rst_n             (rst_n),
        .rd_addr_i         (rd_addr_i),
        .rd_sel_i          (rd_sel_i),
        .dbg_rd_addr_i     (dbg_rd_addr_i),
        .dbg_rd_sel_i      (dbg_rd_sel_i),
        .we_i              (we_i),
        .wr_addr_i         (wr_addr_i),
        .wr_sel_i          (wr_sel_i),
        .wdata_i           (wdata_i),
        .hw_int_i          (hw_int_i),
        .clean_exl_i       (clean_exl),
        .en_exp_i          (en_exp),
        .exp_epc_i         (exp_epc),
        .exp_bd_i          (exp_bd),
        .exp_code_i        (exp_code),
        .exp_bad_vaddr_i   (exp_bad_vaddr),
        .exp_badv_we_i     (exp_badv_we),
        .exp_asid_i        (exp_asid),
        .exp_asid_we_i     (exp_asid_we),
        .we_probe_i        (we_probe_i),
        .probe_result_i    (probe_result_i),
        .rdata_o           (rdata_o),
        .dbg_rdata_o       (dbg_rdata_o),
        .timer_int_o       (timer_int_o),
        .user_mode_o       (user_mode_o),
        .ebase_o           (ebase),
        .epc_o             (epc),
        .tlb_config_o      (tlb_config_o),
        .allow_int_o       (allow_int),
        .software_int_o    (software_int),
        .interrupt_mask_o  (interrupt_mask),
        .special_int_vec_o (special_int_vec),
        .boot_exp_vec_o    (boot_exp_vec),
        .asid_o            (asid_o),
        .in_exl_o          (in_exl)
    );

    cp0_exc_ctrl i_cp0_exc_ctrl (
        .exc_valid_i       (exc_valid_i),
        .exc_code_i        (exc_code_i),
        .exc_pc_i          (exc_pc_i),
        .exc_bd_i          (exc_bd_i),
        .exc_bad_vaddr_i   (exc_bad_vaddr_i),
        .exc_asid_i        (exc_asid_i),
        .eret_i            (eret_i),
        .hw_int_i          (hw_int_i),
        .timer_int_i       (timer_int_o),
        .software_int_i    (software_int),
        .interrupt_mask_i  (interrupt_mask),
        .allow_int_i       (allow_int),
        .in_exl_i          (in_exl),
        .special_int_vec_i (special_int_vec),
        .boot_exp_vec_i    (boot_exp_vec),
        .ebase_i           (ebase),
        .epc_i             (epc),
        .take_exc_o        (take_exc_o),
        .target_pc_o       (target_pc_o),
        .en_exp_o          (en_exp),
        .exp_code_o        (exp_code),
        .exp_epc_o         (exp_epc),
        .exp_bd_o          (exp_bd),
        .exp_bad_vaddr_o   (exp_bad_vaddr),
        .exp_badv_we_o     (exp_badv_we),
        .exp_asid_o        (exp_asid),
        .exp_asid_we_o     (exp_asid_we),
        .clean_exl_o       (clean_exl)
    );

endmodule

`default_nettype wire

//--- sim/cp0_cases.txt
# columns: op sel data aux expected, all hex; sel is {reg number, select}
# EXC sel is {bd, 2'b0, code} and aux is BadVAddr; IRQ data is hw_int_i, aux is PC
READ 60 0 0 10400004
DREAD 60 0 0 10400004
READ 79 0 0 80000000
DREAD 79 0 0 80000000
READ 78 0 0 00018000
READ 81 0 0 1E000000
DREAD 81 0 0 1E000000
WRITE 60 FFFFFFFF 0 0
READ 60 0 0 1040FF17
WRITE 68 FFFFFFFF 0 0
READ 68 0 3F 0080FF00
READ 38 0 0 00000000
READ 61 0 0 00000000
WRITE 68 00000000 0 0
WRITE 60 10400000 0 0
EXC 08 80001000 0 BFC00380
ERET 0 0 0 80001000
EXC 88 80002004 0 BFC00380
ERET 0 0 0 80002000
WRITE 60 10000000 0 0
WRITE 79 80010000 0 0
READ 79 0 0 80010000
EXC 04 80003000 00400123 80010180
READ 40 0 0 00400123
ERET 0 0 0 80003000
WRITE 60 10000401 0 0
IRQ 0 01 80004000 80010180
ERET 0 0 0 80004000
WRITE 68 00800000 0 0
IRQ 0 01 80005000 80010200
ERET 0 0 0 80005000
WRITE 60 10000001 0 0
IRQ 0 01 80006000 00000000
DREAD 70 0 0 80005000
WRITE 48 00000100 0 0
WRITE 58 00000104 0 0
WAITTIMER 0 0 0 1
WRITE 58 00001000 0 0
WAITTIMER 0 0 0 0

//--- sim/cp0_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cp0_tb;

    localparam int CLK_PERIOD     = 20;
    localparam int DRIVE_DELAY    = 2;
    localparam int MAX_TIMER_WAIT = 64;

    logic               clk;
    logic               rst_n;
    logic [4:0]         rd_addr_i;
    logic [2:0]         rd_sel_i;
    logic [4:0]         dbg_rd_addr_i;
    logic [2:0]         dbg_rd_sel_i;
    logic               we_i;
    logic [4:0]         wr_addr_i;
    logic [2:0]         wr_sel_i;
    logic [31:0]        wdata_i;
    logic [5:0]         hw_int_i;
    logic               we_probe_i;
    logic [31:0]        probe_result_i;
    logic               exc_valid_i;
    cp0_pkg::exc_code_e exc_code_i;
    logic [31:0]        exc_pc_i;
    logic               exc_bd_i;
    logic [31:0]        exc_bad_vaddr_i;
    logic [7:0]         exc_asid_i;
    logic               eret_i;
    logic [31:0]        rdata_o;
    logic [31:0]        dbg_rdata_o;
    logic               take_exc_o;
    logic [31:0]        target_pc_o;
    logic               timer_int_o;
    logic               user_mode_o;
    logic [7:0]         asid_o;
    logic [83:0]        tlb_config_o;

    // One entry per case line
    string       op_q[$];
    logic [31:0] sel_q[$];
    logic [31:0] data_q[$];
    logic [31:0] aux_q[$];
    logic [31:0] exp_q[$];
    logic        cases_loaded;

    cp0_top i_cp0_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_addr_i       (rd_addr_i),
        .rd_sel_i        (rd_sel_i),
        .dbg_rd_addr_i   (dbg_rd_addr_i),
        .dbg_rd_sel_i    (dbg_rd_sel_i),
        .we_i            (we_i),
        .wr_addr_i       (wr_addr_i),
        .wr_sel_i        (wr_sel_i),
        .wdata_i         (wdata_i),
        .hw_int_i        (hw_int_i),
        .we_probe_i      (we_probe_i),
        .probe_result_i  (probe_result_i),
        .exc_valid_i     (exc_valid_i),
        .exc_code_i      (exc_code_i),
        .exc_pc_i        (exc_pc_i),
        .exc_bd_i        (exc_bd_i),
        .exc_bad_vaddr_i (exc_bad_vaddr_i),
        .exc_asid_i      (exc_asid_i),
        .eret_i          (eret_i),
        .rdata_o         (rdata_o),
        .dbg_rdata_o     (dbg_rdata_o),
        .take_exc_o      (take_exc_o),
        .target_pc_o     (target_pc_o),
        .timer_int_o     (timer_int_o),
        .user_mode_o     (user_mode_o),
        .asid_o          (asid_o),
        .tlb_config_o    (tlb_config_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_error();
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_code(input string name, input cp0_pkg::exc_code_e exp,
                              input cp0_pkg::exc_code_e act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %s (%0d) actual %s (%0d)", $time, name,
                     exp.name(), exp, act.name(), act);
            stop_on_error();
        end
    endtask

    task automatic check_tlb_config(input string name, input logic [83:0] exp,
                                    input logic [83:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic next_drive_point();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic write_reg(input logic [7:0] sel, input logic [31:0] data);
        we_i      = 1'b1;
        wr_addr_i = sel[7:3];
        wr_sel_i  = sel[2:0];
        wdata_i   = data;
        next_drive_point();
        we_i      = 1'b0;
    endtask

    task automatic read_main(input logic [7:0] sel, output logic [31:0] data);
        rd_addr_i = sel[7:3];
        rd_sel_i  = sel[2:0];
        @(negedge clk);
        data = rdata_o;
        next_drive_point();
    endtask

    task automatic check_read(input logic [7:0] sel, input logic [5:0] hw,
                              input logic [31:0] exp);
        logic [31:0] data;
        hw_int_i = hw; // Shows up in Cause IP7..IP2
        read_main(sel, data);
        hw_int_i = 6'b0;
        check_word($sformatf("rdata_o sel %h", sel), exp, data);
    endtask

    task automatic check_dbg_read(input logic [7:0] sel, input logic [31:0] exp);
        logic [31:0] data;
        dbg_rd_addr_i = sel[7:3];
        dbg_rd_sel_i  = sel[2:0];
        @(negedge clk);
        data = dbg_rdata_o;
        next_drive_point();
        check_word($sformatf("dbg_rdata_o sel %h", sel), exp, data);
    endtask

    task automatic apply_exception(input logic [7:0] sel, input logic [31:0] pc,
                                   input logic [31:0] badv, input logic [31:0] exp_target);
        logic [31:0]        data;
        logic [31:0]        exp_epc;
        cp0_pkg::exc_code_e code;
        code    = cp0_pkg::exc_code_e'(sel[4:0]);
        exp_epc = sel[7] ? pc - 32'd4 : pc; // Branch delay points back at the branch
        exc_valid_i     = 1'b1;
        exc_code_i      = code;
        exc_pc_i        = pc;
        exc_bd_i        = sel[7];
        exc_bad_vaddr_i = badv;
        @(negedge clk);
        check_word("take_exc_o", 32'd1, {31'b0, take_exc_o});
        check_word("target_pc_o", exp_target, target_pc_o);
        next_drive_point();
        exc_valid_i = 1'b0;
        exc_bd_i    = 1'b0;
        read_main(cp0_pkg::EPC, data);
        check_word("EPC", exp_epc, data);
        read_main(cp0_pkg::CAUSE, data);
        check_code("Cause.ExcCode", code, cp0_pkg::exc_code_e'(data[6:2]));
        read_main(cp0_pkg::STATUS, data);
        check_word("Status.EXL", 32'd1, {31'b0, data[1]});
    endtask

    task automatic apply_eret(input logic [31:0] exp_target);
        logic [31:0] data;
        eret_i = 1'b1;
        @(negedge clk);
        check_word("take_exc_o", 32'd1, {31'b0, take_exc_o});
        check_word("target_pc_o", exp_target, target_pc_o);
        next_drive_point();
        eret_i = 1'b0;
        read_main(cp0_pkg::STATUS, data);
        check_word("Status.EXL", 32'd0, {31'b0, data[1]});
    endtask

    // Target of zero means the interrupt must stay masked
    task automatic drive_irq(input logic [5:0] hw, input logic [31:0] pc,
                             input logic [31:0] exp_target);
        logic [31:0] data;
        hw_int_i = hw;
        exc_pc_i = pc;
        exc_bd_i = 1'b0;
        @(negedge clk);
        if (exp_target != 32'b0) begin
            check_word("take_exc_o", 32'd1, {31'b0, take_exc_o});
            check_word("target_pc_o", exp_target, target_pc_o);
        end else begin
            check_word("take_exc_o", 32'd0, {31'b0, take_exc_o});
        end
        next_drive_point();
        hw_int_i = 6'b0;
        if (exp_target != 32'b0) begin
            read_main(cp0_pkg::CAUSE, data);
            check_code("Cause.ExcCode", cp0_pkg::INT, cp0_pkg::exc_code_e'(data[6:2]));
            read_main(cp0_pkg::EPC, data);
            check_word("EPC", pc, data);
        end
    endtask

    task automatic wait_timer(input logic expect_high);
        int waited;
        if (expect_high) begin
            waited = 0;
            while (timer_int_o !== 1'b1 && waited < MAX_TIMER_WAIT) begin
                next_drive_point();
                waited++;
            end
            if (timer_int_o !== 1'b1) begin
                $display("timer interrupt never rose within %0d cycles", MAX_TIMER_WAIT);
                stop_on_error();
            end
        end else begin
            @(negedge clk);
            check_word("timer_int_o", 32'd0, {31'b0, timer_int_o});
            next_drive_point();
        end
    endtask

    // TLB staging outputs, probe capture, ASID capture and user mode
    task automatic check_tlb_outputs();
        logic [31:0] data;
        write_reg(cp0_pkg::ENTRYHI, 32'h0000_20C5);
        write_reg(cp0_pkg::ENTRYLO0, 32'h0000_0047);
        write_reg(cp0_pkg::ENTRYLO1, 32'h0000_0083);
        write_reg(cp0_pkg::INDEX, 32'h0000_0009);
        check_word("asid_o", 32'h0000_00C5, {24'b0, asid_o});
        check_tlb_config("tlb_config_o",
                         {8'hC5, 1'b1, 19'h1, 24'h2, 2'b01, 24'h1, 2'b11, 4'h9},
                         tlb_config_o);
        we_probe_i     = 1'b1;
        probe_result_i = 32'h8000_0003; // Miss, index 3
        next_drive_point();
        we_probe_i = 1'b0;
        read_main(cp0_pkg::INDEX, data);
        check_word("Index", 32'h8000_0003, data);
        check_word("user_mode_o", 32'd0, {31'b0, user_mode_o});
        write_reg(cp0_pkg::STATUS, 32'h1000_0010); // UM only
        check_word("user_mode_o", 32'd1, {31'b0, user_mode_o});
        exc_asid_i = 8'h3A;
        apply_exception(8'h02, 32'h8000_7000, 32'h0000_6000, 32'h8001_0180); // TLBL
        check_word("asid_o", 32'h0000_003A, {24'b0, asid_o});
        check_word("user_mode_o", 32'd0, {31'b0, user_mode_o});
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        string       op;
        string       line;
        logic [31:0] f [4];
        fd = $fopen("sim/cp0_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file sim/cp0_cases.txt");
            stop_on_error();
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", op);
            if (n != 1) begin
                break;
            end
            if (op.substr(0, 0) == "#") begin
                n = $fgets(line, fd); // Skip comment text
            end else begin
                n = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]);
                if (n != 4) begin
                    $display("case file line for %s does not hold four hex fields", op);
                    stop_on_error();
                end
                op_q.push_back(op);
                sel_q.push_back(f[0]);
                data_q.push_back(f[1]);
                aux_q.push_back(f[2]);
                exp_q.push_back(f[3]);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int idx;
        rst_n           = 1'b0;
        rd_addr_i       = 5'b0;
        rd_sel_i        = 3'b0;
        dbg_rd_addr_i   = 5'b0;
        dbg_rd_sel_i    = 3'b0;
        we_i            = 1'b0;
        wr_addr_i       = 5'b0;
        wr_sel_i        = 3'b0;
        wdata_i         = 32'b0;
        hw_int_i        = 6'b0;
        we_probe_i      = 1'b0;
        probe_result_i  = 32'b0;
        exc_valid_i     = 1'b0;
        exc_code_i      = cp0_pkg::INT;
        exc_pc_i        = 32'b0;
        exc_bd_i        = 1'b0;
        exc_bad_vaddr_i = 32'b0;
        exc_asid_i      = 8'b0;
        eret_i          = 1'b0;
        cases_loaded    = 1'b0;
        load_cases();
        cases_loaded = 1'b1;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        for (idx = 0; idx < op_q.size(); idx++) begin
            case (op_q[idx])
                "WRITE":     write_reg(sel_q[idx][7:0], data_q[idx]);
                "READ":      check_read(sel_q[idx][7:0], aux_q[idx][5:0], exp_q[idx]);
                "DREAD":     check_dbg_read(sel_q[idx][7:0], exp_q[idx]);
                "EXC":       apply_exception(sel_q[idx][7:0], data_q[idx], aux_q[idx],
                                             exp_q[idx]);
                "ERET":      apply_eret(exp_q[idx]);
                "IRQ":       drive_irq(data_q[idx][5:0], aux_q[idx], exp_q[idx]);
                "WAITTIMER": wait_timer(exp_q[idx][0]);
                default: begin
                    $display("unknown operation %s in the case file", op_q[idx]);
                    stop_on_error();
                end
            endcase
        end
        check_tlb_outputs();
        $display("NO ERRORS");
        $finish;
    end

    // Watchdog sized from the number of cases
    initial begin
        wait (cases_loaded);
        repeat ((op_q.size() + 10) * 100) @(posedge clk);
        $display("watchdog expired before the case list finished");
        stop_on_error();
    end

endmodule

`default_nettype wire

//--- verilog.f
hdl/cp0_pkg.sv
hdl/cp0_regfile.sv
hdl/cp0_exc_ctrl.sv
hdl/cp0_top.sv
sim/cp0_tb.sv
